// ==== compile.f ====
+incdir+include
verilog/sdmacPkg.sv
verilog/sdmacRegs.sv
verilog/dmaFsm.sv
verilog/xferCounter.sv
verilog/wordFifo.sv
verilog/scsiPacker.sv
verilog/sdmacDatapath.sv
verilog/sdmacTop.sv
dv/tbClock.sv
dv/sdmacTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = sdmacTb
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/sdmacTb.sv ====
`timescale 1ns/10ps
`include "sdmac_consts.svh"

module sdmacTb;
    localparam int NUM_ROWS        = 7;
    localparam int CYCLES_PER_BYTE = 20;
    localparam int SAMPLE_DELAY    = 1;

    // One transfer per row with its expected word count
    // stallMask sets how often pdOutReady drops and holdReads delays all DATA reads
    typedef struct packed {
        logic        dir;
        logic [15:0] len;
        logic [7:0]  stallMask;
        logic        holdReads;
        logic [7:0]  expWords;
    } testRow_t;

    logic                CLK;
    logic                rstN;
    sdmacPkg::apbReq_t   apbReq;
    sdmacPkg::apbRsp_t   apbRsp;
    sdmacPkg::scsiByte_t pdIn;
    logic                pdInValid;
    logic                pdInReady;
    sdmacPkg::scsiByte_t pdOut;
    logic                pdOutValid;
    logic                pdOutReady;

    testRow_t            rows [NUM_ROWS];
    sdmacPkg::scsiByte_t byteQ [$];
    sdmacPkg::fifoWord_u wordQ [$];
    int                  seed;
    int                  cycles;
    int                  cycleLimit;
    logic                sawStall;
    logic                xferEnded;

    tbClock u_tbClock (.CLK(CLK), .rstN(rstN));

    sdmacTop u_sdmacTop (.*);

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compareWord(input string name, input sdmacPkg::fifoWord_u got,
                               input sdmacPkg::fifoWord_u exp);
        if (got.word !== exp.word) begin
            abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got.word, exp.word));
        end
    endtask

    task automatic compareByte(input string name, input sdmacPkg::scsiByte_t got,
                               input sdmacPkg::scsiByte_t exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareStatus(input string name, input sdmacPkg::statusReg_t got,
                                 input sdmacPkg::statusReg_t exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareErr(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Setup phase on one falling edge and access phase on the next
    // The response is sampled inside the access cycle before the rising edge commits it
    task automatic apbAccess(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
        @(negedge CLK);
        apbReq.paddr   = addr;
        apbReq.pwrite  = write;
        apbReq.pwdata  = wdata;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        @(negedge CLK);
        apbReq.penable = 1'b1;
        #SAMPLE_DELAY;
        compareFlag("pready", apbRsp.pready, 1'b1);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(negedge CLK);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apbAccess(1'b1, addr, wdata, rdata, err);
        compareErr("pslverr on write", err, 1'b0);
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
        apbAccess(1'b0, addr, '0, rdata, err);
    endtask

    task automatic readStatus(output sdmacPkg::statusReg_t st);
        logic [31:0] rdata;
        logic        err;
        apbRead(`SDMAC_ADDR_STATUS, rdata, err);
        compareErr("pslverr on STATUS read", err, 1'b0);
        st = rdata[$bits(sdmacPkg::statusReg_t)-1:0];
    endtask

    task automatic waitForDone(output sdmacPkg::statusReg_t st);
        st = '0;
        while (!st.done) begin
            readStatus(st);
        end
    endtask

    // Inbound bytes are random and the words expected from them follow little-endian order
    task automatic makeInbound(input int len, input int nWords);
        sdmacPkg::fifoWord_u w;
        sdmacPkg::scsiByte_t b;
        for (int k = 0; k < nWords; k++) begin
            w.word = '0;
            for (int ln = 0; ln < 4; ln++) begin
                if (4 * k + ln < len) begin
                    b = 8'($random(seed));
                    byteQ.push_back(b);
                    w.word = w.word | (32'(b) << (8 * ln));
                end
            end
            wordQ.push_back(w);
        end
    endtask

    // Outbound words are random and only the first len lanes count
    task automatic makeOutbound(input int len, input int nWords);
        sdmacPkg::fifoWord_u w;
        for (int k = 0; k < nWords; k++) begin
            w.word = $random(seed);
            wordQ.push_back(w);
            for (int ln = 0; ln < 4; ln++) begin
                if (4 * k + ln < len) begin
                    byteQ.push_back(8'(w.word >> (8 * ln)));
                end
            end
        end
    endtask

    // SCSI source holds each byte until the DUT shows ready
    task automatic sendBytes();
        for (int i = 0; i < byteQ.size(); i++) begin
            @(negedge CLK);
            pdIn      = byteQ[i];
            pdInValid = 1'b1;
            #SAMPLE_DELAY;
            while (!pdInReady) begin
                sawStall = 1'b1;
                @(negedge CLK);
                #SAMPLE_DELAY;
            end
        end
        @(negedge CLK);
        pdInValid = 1'b0;
    endtask

    task automatic waitInStall();
        @(negedge CLK);
        #SAMPLE_DELAY;
        while (!(pdInValid && !pdInReady)) begin
            @(negedge CLK);
            #SAMPLE_DELAY;
        end
    endtask

    task automatic drainWords(input logic hold);
        sdmacPkg::statusReg_t st;
        sdmacPkg::statusReg_t expSt;
        sdmacPkg::fifoWord_u  got;
        logic [31:0]          rdata;
        logic                 err;
        if (hold) begin
            // Nothing is read until the FIFO is full and the packer has stopped the source
            st = '0;
            while (st.fifoLevel != 4'(`SDMAC_FIFO_DEPTH)) begin
                readStatus(st);
            end
            waitInStall();
            readStatus(st);
            expSt = '{busy: 1'b1, done: 1'b0, fifoLevel: 4'(`SDMAC_FIFO_DEPTH)};
            compareStatus("status while stalled", st, expSt);
        end
        for (int k = 0; k < wordQ.size(); k++) begin
            st = '0;
            while (st.fifoLevel == '0) begin
                readStatus(st);
            end
            apbRead(`SDMAC_ADDR_DATA, rdata, err);
            compareErr("pslverr on DATA read", err, 1'b0);
            got.word = rdata;
            compareWord("DATA word", got, wordQ[k]);
        end
    endtask

    // SCSI sink with random stalls that counts every handshake it sees
    task automatic receiveBytes(input int len, input logic [7:0] mask);
        int got;
        got = 0;
        while (!xferEnded) begin
            @(negedge CLK);
            pdOutReady = (8'($random(seed)) & mask) == 8'h00;
            #SAMPLE_DELAY;
            if (pdOutValid && pdOutReady) begin
                if (got >= len) begin
                    abortRun("pdOut offered a byte beyond the transfer length");
                end else begin
                    compareByte("pdOut", pdOut, byteQ[got]);
                    got++;
                end
            end
        end
        if (got != len) begin
            abortRun($sformatf("pdOut delivered %0d bytes but %0d were expected", got, len));
        end
    endtask

    task automatic runScsiToCpu(input testRow_t row);
        sdmacPkg::ctrlReg_t   ctrl;
        sdmacPkg::statusReg_t st;
        sdmacPkg::statusReg_t expSt;
        makeInbound(row.len, row.expWords);
        ctrl = '{start: 1'b1, dir: 1'b1};
        apbWrite(`SDMAC_ADDR_LEN, 32'(row.len));
        apbWrite(`SDMAC_ADDR_CTRL, 32'(ctrl));
        fork
            sendBytes();
            drainWords(row.holdReads);
        join
        // pdInReady drops only when held-back reads let the FIFO fill up
        compareFlag("pdInReady stall seen", sawStall, row.holdReads);
        waitForDone(st);
        expSt = '{busy: 1'b0, done: 1'b1, fifoLevel: 4'd0};
        compareStatus("status after inbound transfer", st, expSt);
    endtask

    task automatic runCpuToScsi(input testRow_t row);
        sdmacPkg::ctrlReg_t   ctrl;
        sdmacPkg::statusReg_t st;
        sdmacPkg::statusReg_t expSt;
        // Direction goes outbound first so DATA writes land in the FIFO
        ctrl = '{start: 1'b0, dir: 1'b0};
        apbWrite(`SDMAC_ADDR_CTRL, 32'(ctrl));
        makeOutbound(row.len, row.expWords);
        for (int k = 0; k < wordQ.size(); k++) begin
            apbWrite(`SDMAC_ADDR_DATA, wordQ[k].word);
        end
        apbWrite(`SDMAC_ADDR_LEN, 32'(row.len));
        ctrl.start = 1'b1;
        apbWrite(`SDMAC_ADDR_CTRL, 32'(ctrl));
        fork
            receiveBytes(row.len, row.stallMask);
            begin
                waitForDone(st);
                xferEnded = 1'b1;
            end
        join
        @(negedge CLK);
        pdOutReady = 1'b0;
        expSt = '{busy: 1'b0, done: 1'b1, fifoLevel: 4'd0};
        compareStatus("status after outbound transfer", st, expSt);
    endtask

    task automatic checkResetState();
        sdmacPkg::statusReg_t st;
        logic [31:0]          rdata;
        logic                 err;
        @(negedge CLK);
        #SAMPLE_DELAY;
        compareFlag("pdInReady after reset", pdInReady, 1'b0);
        compareFlag("pdOutValid after reset", pdOutValid, 1'b0);
        readStatus(st);
        compareStatus("status after reset", st, '0);
        // An empty FIFO cannot serve a DATA read
        apbRead(`SDMAC_ADDR_DATA, rdata, err);
        compareErr("pslverr on empty DATA read", err, 1'b1);
        readStatus(st);
        compareStatus("status after empty read", st, '0);
    endtask

    task automatic loadTable();
        rows[0] = '{dir: 1'b1, len: 16'd16, stallMask: 8'h00, holdReads: 1'b0, expWords: 8'd4};
        rows[1] = '{dir: 1'b1, len: 16'd5,  stallMask: 8'h00, holdReads: 1'b0, expWords: 8'd2};
        rows[2] = '{dir: 1'b1, len: 16'd7,  stallMask: 8'h00, holdReads: 1'b0, expWords: 8'd2};
        rows[3] = '{dir: 1'b0, len: 16'd12, stallMask: 8'h00, holdReads: 1'b0, expWords: 8'd3};
        rows[4] = '{dir: 1'b0, len: 16'd7,  stallMask: 8'h01, holdReads: 1'b0, expWords: 8'd2};
        rows[5] = '{dir: 1'b0, len: 16'd30, stallMask: 8'h03, holdReads: 1'b0, expWords: 8'd8};
        // Ten words is more than the FIFO and the packer can hold together
        rows[6] = '{dir: 1'b1, len: 16'd40, stallMask: 8'h00, holdReads: 1'b1, expWords: 8'd10};
    endtask

    function automatic int timeoutCycles();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += int'(rows[r].len);
        end
        return total * CYCLES_PER_BYTE + 200;
    endfunction

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            abortRun($sformatf("Timeout after %0d cycles with the transfers unfinished", cycles));
        end
    end

    initial begin
        seed       = 77540;
        cycles     = 0;
        apbReq     = '0;
        pdIn       = '0;
        pdInValid  = 1'b0;
        pdOutReady = 1'b0;
        sawStall   = 1'b0;
        xferEnded  = 1'b0;
        loadTable();
        cycleLimit = timeoutCycles();
        @(posedge rstN);
        checkResetState();
        for (int r = 0; r < NUM_ROWS; r++) begin
            byteQ.delete();
            wordQ.delete();
            sawStall  = 1'b0;
            xferEnded = 1'b0;
            if (rows[r].dir) begin
                runScsiToCpu(rows[r]);
            end else begin
                runCpuToScsi(rows[r]);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/10ps

module tbClock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic CLK,
    output logic rstN
);
    // Free-running clock whose first rising edge comes half a period in
    initial begin
        CLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) CLK = ~CLK;
        end
    end

    // Reset covers a fixed number of rising edges and lifts on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;
    end

endmodule

// ==== verilog/sdmacTop.sv ====
`timescale 1ns/10ps
`include "sdmac_consts.svh"

module sdmacTop (
    input  logic                CLK,
    input  logic                rstN,
    input  sdmacPkg::apbReq_t   apbReq,
    output sdmacPkg::apbRsp_t   apbRsp,
    input  sdmacPkg::scsiByte_t pdIn,
    input  logic                pdInValid,
    output logic                pdInReady,
    output sdmacPkg::scsiByte_t pdOut,
    output logic                pdOutValid,
    input  logic                pdOutReady
);
    sdmacPkg::ctrlReg_t      ctrl;
    sdmacPkg::statusReg_t    status;
    sdmacPkg::fifoWord_u     cpuWdata;
    sdmacPkg::fifoWord_u     cpuRdata;
    logic [`SDMAC_LEN_W-1:0] len;
    logic [3:0]              fifoLevel;
    logic                    startPulse;
    logic                    cpuPush;
    logic                    cpuPop;
    logic                    fifoFull;
    logic                    fifoEmpty;
    logic                    runEn;
    logic                    counterLoad;
    logic                    flushReq;
    logic                    busy;
    logic                    done;
    logic                    zero;
    logic                    byteTaken;
    logic                    partial;

    // STATUS gathers the FSM flags and the FIFO fill level
    assign status = '{busy: busy, done: done, fifoLevel: fifoLevel};

    // Local signals carry the same names as the ports they feed
    sdmacRegs u_sdmacRegs (.*);

    dmaFsm u_dmaFsm (.*);

    // Every SCSI handshake consumes one byte of the length
    xferCounter u_xferCounter (
        .CLK  (CLK        ),
        .rstN (rstN       ),
        .load (counterLoad),
        .len  (len        ),
        .dec  (byteTaken  ),
        .zero (zero       )
    );

    sdmacDatapath u_sdmacDatapath (.*);

endmodule

// ==== verilog/sdmacDatapath.sv ====
`timescale 1ns/10ps

module sdmacDatapath (
    input  logic                CLK,
    input  logic                rstN,
    input  sdmacPkg::ctrlReg_t  ctrl,
    input  logic                runEn,
    input  logic                flushReq,
    input  sdmacPkg::scsiByte_t pdIn,
    input  logic                pdInValid,
    output logic                pdInReady,
    output sdmacPkg::scsiByte_t pdOut,
    output logic                pdOutValid,
    input  logic                pdOutReady,
    input  logic                cpuPush,
    input  logic                cpuPop,
    input  sdmacPkg::fifoWord_u cpuWdata,
    output sdmacPkg::fifoWord_u cpuRdata,
    output logic [3:0]          fifoLevel,
    output logic                fifoFull,
    output logic                fifoEmpty,
    output logic                byteTaken,
    output logic                partial
);
    sdmacPkg::fifoWord_u packWord;
    sdmacPkg::fifoWord_u pushData;
    logic                packValid;
    logic                packTake;
    logic                push;
    logic                pop;
    logic                wordAvail;

    // Inbound the packer fills the FIFO and the CPU drains it
    // Outbound the roles swap
    assign push     = ctrl.dir ? (packValid & ~fifoFull) : cpuPush;
    assign pushData = ctrl.dir ? packWord : cpuWdata;
    assign pop      = ctrl.dir ? cpuPop : packTake;

    // The packer sees FIFO room inbound and FIFO contents outbound
    assign wordAvail = ctrl.dir ? ~fifoFull : ~fifoEmpty;

    wordFifo u_wordFifo (
        .CLK      (CLK      ),
        .rstN     (rstN     ),
        .push     (push     ),
        .pushData (pushData ),
        .pop      (pop      ),
        .popData  (cpuRdata ),
        .level    (fifoLevel),
        .full     (fifoFull ),
        .empty    (fifoEmpty)
    );

    scsiPacker u_scsiPacker (
        .CLK          (CLK       ),
        .rstN         (rstN      ),
        .runEn        (runEn     ),
        .dir          (ctrl.dir  ),
        .flushReq     (flushReq  ),
        .pdIn         (pdIn      ),
        .pdInValid    (pdInValid ),
        .pdInReady    (pdInReady ),
        .pdOut        (pdOut     ),
        .pdOutValid   (pdOutValid),
        .pdOutReady   (pdOutReady),
        .wordOut      (packWord  ),
        .wordOutValid (packValid ),
        .wordIn       (cpuRdata  ),
        .wordInAvail  (wordAvail ),
        .wordInTake   (packTake  ),
        .byteTaken    (byteTaken ),
        .partial      (partial   )
    );

endmodule

// ==== verilog/scsiPacker.sv ====
`timescale 1ns/10ps

module scsiPacker (
    input  logic                CLK,
    input  logic                rstN,
    input  logic                runEn,
    input  logic                dir,
    input  logic                flushReq,
    input  sdmacPkg::scsiByte_t pdIn,
    input  logic                pdInValid,
    output logic                pdInReady,
    output sdmacPkg::scsiByte_t pdOut,
    output logic                pdOutValid,
    input  logic                pdOutReady,
    output sdmacPkg::fifoWord_u wordOut,
    output logic                wordOutValid,
    input  sdmacPkg::fifoWord_u wordIn,
    input  logic                wordInAvail,
    output logic                wordInTake,
    output logic                byteTaken,
    output logic                partial
);
    // One lane index and one word register serve both directions
    logic [1:0]          lane;
    sdmacPkg::fifoWord_u laneWord;
    logic                wordHeld;
    logic                wordLoaded;
    logic                inFire;
    logic                outFire;
    logic                lastLane;

    assign lastLane = lane == 2'd3;

    // Inbound bytes stall only while a finished word waits for FIFO room
    // In this direction wordInAvail reports free space in the FIFO
    assign pdInReady = runEn & dir & (~wordHeld | wordInAvail);
    assign inFire    = pdInValid & pdInReady;

    // Outbound bytes come from the loaded word in lane order
    assign pdOutValid = runEn & ~dir & wordLoaded;
    assign outFire    = pdOutValid & pdOutReady;
    assign pdOut      = laneWord.lanes[lane];

    // The next word is fetched as the last lane of the current one leaves
    assign wordInTake = runEn & ~dir & wordInAvail & (~wordLoaded | (outFire & lastLane));

    assign wordOut      = laneWord;
    assign wordOutValid = wordHeld;
    assign byteTaken    = inFire | outFire;
    // Some lanes of an inbound word are filled but not yet offered
    assign partial      = lane != 2'd0;

    always_ff @(posedge CLK) begin
        if (wordInTake) begin
            laneWord <= wordIn;
        end else if (inFire) begin
            // Starting a word clears the upper lanes so a flush pads with zeros
            if (lane == 2'd0) begin
                laneWord.word <= {24'h0, pdIn};
            end else begin
                laneWord.lanes[lane] <= pdIn;
            end
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            lane       <= '0;
            wordHeld   <= 1'b0;
            wordLoaded <= 1'b0;
        end else begin
            // Lanes restart at zero for every transfer
            if (!runEn) begin
                lane <= '0;
            end else if (byteTaken) begin
                lane <= lane + 2'd1;
            end
            // A held word leaves once the FIFO has room for it
            if (wordHeld && wordInAvail) begin
                wordHeld <= 1'b0;
            end
            if ((inFire && lastLane) || flushReq) begin
                wordHeld <= 1'b1;
            end
            // Lanes left over at the end of an outbound transfer are dropped
            if (!runEn) begin
                wordLoaded <= 1'b0;
            end else if (wordInTake) begin
                wordLoaded <= 1'b1;
            end else if (outFire && lastLane) begin
                wordLoaded <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/wordFifo.sv ====
`timescale 1ns/10ps
`include "sdmac_consts.svh"

module wordFifo #(
    parameter int DEPTH = `SDMAC_FIFO_DEPTH
) (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         push,
    input  sdmacPkg::fifoWord_u          pushData,
    input  logic                         pop,
    output sdmacPkg::fifoWord_u          popData,
    output logic [$clog2(DEPTH+1)-1:0]   level,
    output logic                         full,
    output logic                         empty
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LVL_W = $clog2(DEPTH + 1);

    sdmacPkg::fifoWord_u mem [DEPTH];
    logic [PTR_W-1:0]    wrPtr;
    logic [PTR_W-1:0]    rdPtr;

    // Storage is written only where the write pointer points
    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // First word falls through so readers see the head without a pop
    assign popData = mem[rdPtr];
    assign full    = level == LVL_W'(DEPTH);
    assign empty   = level == '0;

    // Both producers and consumers must respect the flags
    noPushFull: assert property (@(posedge CLK) disable iff (!rstN) push |-> !full);
    noPopEmpty: assert property (@(posedge CLK) disable iff (!rstN) pop |-> !empty);

endmodule

// ==== verilog/xferCounter.sv ====
`timescale 1ns/10ps
`include "sdmac_consts.svh"

module xferCounter (
    input  logic                    CLK,
    input  logic                    rstN,
    input  logic                    load,
    input  logic [`SDMAC_LEN_W-1:0] len,
    input  logic                    dec,
    output logic                    zero
);
    // Bytes still to move in the current transfer
    logic [`SDMAC_LEN_W-1:0] count;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= len;
        end else if (dec) begin
            count <= count - 1'b1;
        end
    end

    assign zero = count == '0;

    // The FSM closes the byte port before the count can wrap
    noDecAtZero: assert property (@(posedge CLK) disable iff (!rstN)
        dec |-> !zero);

endmodule

// ==== verilog/dmaFsm.sv ====
`timescale 1ns/10ps

module dmaFsm (
    input  logic               CLK,
    input  logic               rstN,
    input  logic               startPulse,
    input  sdmacPkg::ctrlReg_t ctrl,
    input  logic               zero,
    input  logic               partial,
    output logic               runEn,
    output logic               counterLoad,
    output logic               flushReq,
    output logic               busy,
    output logic               done
);
    sdmacPkg::dmaState_e state;
    sdmacPkg::dmaState_e stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            // A new transfer may follow a finished one directly
            sdmacPkg::IDLE, sdmacPkg::DONE: begin
                if (startPulse) begin
                    stateNext = sdmacPkg::RUN;
                end
            end
            // Only an inbound transfer can leave bytes stranded in the packer
            sdmacPkg::RUN: begin
                if (zero) begin
                    stateNext = (ctrl.dir && partial) ? sdmacPkg::FLUSH : sdmacPkg::DONE;
                end
            end
            sdmacPkg::FLUSH: stateNext = sdmacPkg::DONE;
            default:         stateNext = sdmacPkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state <= sdmacPkg::IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // The counter loads on the same edge that enters RUN
    assign counterLoad = startPulse && (state == sdmacPkg::IDLE || state == sdmacPkg::DONE);
    // Byte traffic stops as soon as the count runs out
    assign runEn    = state == sdmacPkg::RUN && !zero;
    assign flushReq = state == sdmacPkg::FLUSH;
    assign busy     = state == sdmacPkg::RUN || state == sdmacPkg::FLUSH;
    assign done     = state == sdmacPkg::DONE;

    // A start that arrives mid-transfer would be lost
    startWhenIdle: assert property (@(posedge CLK) disable iff (!rstN)
        startPulse |-> (state == sdmacPkg::IDLE || state == sdmacPkg::DONE));

endmodule

// ==== verilog/sdmacRegs.sv ====
`timescale 1ns/10ps
`include "sdmac_consts.svh"

module sdmacRegs (
    input  logic                    CLK,
    input  logic                    rstN,
    input  sdmacPkg::apbReq_t       apbReq,
    output sdmacPkg::apbRsp_t       apbRsp,
    output sdmacPkg::ctrlReg_t      ctrl,
    output logic [`SDMAC_LEN_W-1:0] len,
    output logic                    startPulse,
    input  sdmacPkg::statusReg_t    status,
    output logic                    cpuPush,
    output logic                    cpuPop,
    output sdmacPkg::fifoWord_u     cpuWdata,
    input  sdmacPkg::fifoWord_u     cpuRdata,
    input  logic                    fifoFull,
    input  logic                    fifoEmpty
);
    logic               access;
    logic               wrEn;
    logic               rdEn;
    logic               dataSel;
    sdmacPkg::ctrlReg_t wrCtrl;

    // The access phase is the second cycle of every transfer
    // pready is tied high so nothing ever stretches it
    assign access  = apbReq.psel & apbReq.penable;
    assign wrEn    = access & apbReq.pwrite;
    assign rdEn    = access & ~apbReq.pwrite;
    assign dataSel = apbReq.paddr == `SDMAC_ADDR_DATA;
    assign wrCtrl  = sdmacPkg::ctrlReg_t'(apbReq.pwdata[1:0]);

    // DATA accesses map straight onto FIFO strobes in the access phase
    // A push into a full FIFO or a pop from an empty one is dropped
    assign cpuPush       = wrEn & dataSel & ~fifoFull;
    assign cpuPop        = rdEn & dataSel & ~fifoEmpty;
    assign cpuWdata.word = apbReq.pwdata;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            ctrl       <= '0;
            len        <= '0;
            startPulse <= 1'b0;
        end else begin
            // Start is a single pulse one cycle after the CTRL write
            startPulse <= 1'b0;
            if (wrEn && apbReq.paddr == `SDMAC_ADDR_CTRL) begin
                ctrl       <= wrCtrl;
                startPulse <= wrCtrl.start;
            end
            if (wrEn && apbReq.paddr == `SDMAC_ADDR_LEN) begin
                len <= apbReq.pwdata[`SDMAC_LEN_W-1:0];
            end
        end
    end

    always_comb begin
        apbRsp.prdata  = '0;
        apbRsp.pready  = 1'b1;
        // Error on a DATA access the FIFO cannot serve
        apbRsp.pslverr = access & dataSel & (apbReq.pwrite ? fifoFull : fifoEmpty);
        if (rdEn) begin
            case (apbReq.paddr)
                `SDMAC_ADDR_CTRL:   apbRsp.prdata = 32'(ctrl);
                `SDMAC_ADDR_LEN:    apbRsp.prdata = 32'(len);
                `SDMAC_ADDR_STATUS: apbRsp.prdata = 32'(status);
                // The FIFO head is visible before the pop takes effect
                `SDMAC_ADDR_DATA:   apbRsp.prdata = fifoEmpty ? '0 : cpuRdata.word;
                default:            apbRsp.prdata = '0;
            endcase
        end
    end

    // A CTRL write holds its access phase for one cycle only so start never repeats
    singleStartPulse: assert property (@(posedge CLK) disable iff (!rstN)
        startPulse |=> !startPulse);

endmodule

// ==== verilog/sdmacPkg.sv ====
package sdmacPkg;

    // One byte on the SCSI data port
    typedef logic [7:0] scsiByte_t;

    // APB request as driven by the CPU side
    typedef struct packed {
        logic [3:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apbReq_t;

    // APB response returned by the register block
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp_t;

    // A FIFO word is seen whole by the CPU and as byte lanes by the packer
    // Lane 0 sits in bits 7:0, so lane order is little-endian
    typedef union packed {
        logic [31:0]         word;
        scsiByte_t [3:0]     lanes;
    } fifoWord_u;

    // Direction is 1 when bytes go from SCSI to the CPU
    typedef struct packed {
        logic start;
        logic dir;
    } ctrlReg_t;

    typedef struct packed {
        logic       busy;
        logic       done;
        logic [3:0] fifoLevel;
    } statusReg_t;

    typedef enum logic [1:0] {IDLE, RUN, FLUSH, DONE} dmaState_e;

endpackage

// ==== include/sdmac_consts.svh ====
`ifndef SDMAC_CONSTS_SVH
`define SDMAC_CONSTS_SVH

// Number of 32-bit words the FIFO holds between the CPU and SCSI sides
`define SDMAC_FIFO_DEPTH 8

// Width of the transfer byte counter and of the LEN register
`define SDMAC_LEN_W 16

// APB register map in byte addresses
// CTRL holds the start and direction bits
`define SDMAC_ADDR_CTRL 4'h0
// LEN holds the transfer length in bytes
`define SDMAC_ADDR_LEN 4'h4
// STATUS reports busy, done and the FIFO level
`define SDMAC_ADDR_STATUS 4'h8
// DATA is the FIFO window for the CPU
`define SDMAC_ADDR_DATA 4'hC

`endif
